/* sources.f */
hw/hornerPkg.sv
hw/AddMulPPGenUns.sv
hw/Cpr.sv
hw/AddMopCsv.sv
hw/MulCsvUns.sv
hw/HornerCsvCore.sv
hw/HornerAxiRegs.sv
hw/HornerEvalTop.sv
tb/hornerChecker.sv
tb/tbHornerEval.sv

/* Bender.yml */
package:
  name: horner_eval

sources:
  # design, package first
  - files:
      - hw/hornerPkg.sv
      - hw/AddMulPPGenUns.sv
      - hw/Cpr.sv
      - hw/AddMopCsv.sv
      - hw/MulCsvUns.sv
      - hw/HornerCsvCore.sv
      - hw/HornerAxiRegs.sv
      - hw/HornerEvalTop.sv

  # testbench
  - target: test
    files:
      - tb/hornerChecker.sv
      - tb/tbHornerEval.sv

/* tb/tbHornerEval.sv */
module tbHornerEval
	import hornerPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic isRead;
		axiAddrT addr;
		axiDataT data; // write data
		axiStrbT strb;
		logic [3:0] bDly; // cycles bReady stays low
		logic [3:0] rDly; // cycles rReady stays low
		axiDataT exp; // expected read data
	} entryT;

	logic clk, arstN;
	axiAddrT awAddr, arAddr;
	logic awValid, awReady, wValid, wReady, bValid, bReady;
	logic arValid, arReady, rValid, rReady;
	axiDataT wData, rData;
	axiStrbT wStrb;
	axiRespT bResp, rResp;

	entryT stim [0:63];
	int nEntries;
	accT modelX, modelAcc; // software copy of the registers
	logic [31:0] lcgState;
	int testIdx, doneCount, errorCount, failedCount, testsDone;
	axiDataT expData;
	int cycles;
	int cycleLimit = 0; // set once the table is built

	HornerEvalTop i_dut (.*);

	hornerChecker chk (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic accT lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// acc*x + c, kept mod 2^16
	function automatic accT hornerStep(accT acc, accT xv, accT c);
		logic [31:0] full;
		full = acc * xv + c;
		return full[15:0];
	endfunction

	// unstrobed bytes keep the old value
	function automatic accT mergeLanes(accT old, axiDataT data, axiStrbT strb);
		accT v;
		v = old;
		if (strb[0]) v[7:0] = data[7:0];
		if (strb[1]) v[15:8] = data[15:8];
		return v;
	endfunction

	function automatic accT strobedValue(axiDataT data, axiStrbT strb);
		return mergeLanes(16'h0, data, strb); // masked bytes read as zero
	endfunction

	task automatic addEntry(input logic isRead, input axiAddrT addr, input axiDataT data,
			input axiStrbT strb, input int bDly, input int rDly, input axiDataT exp);
		stim[nEntries] = {isRead, addr, data, strb, 4'(bDly), 4'(rDly), exp};
		nEntries++;
	endtask

	task automatic setX(input axiDataT data, input axiStrbT strb, input int bDly);
		modelX = mergeLanes(modelX, data, strb);
		addEntry(1'b0, regOffX, data, strb, bDly, 0, '0);
	endtask

	task automatic pushCoef(input axiDataT data, input axiStrbT strb, input int bDly);
		modelAcc = hornerStep(modelAcc, modelX, strobedValue(data, strb));
		addEntry(1'b0, regOffCoef, data, strb, bDly, 0, '0);
	endtask

	task automatic clearAcc();
		modelAcc = '0;
		addEntry(1'b0, regOffCtrl, 32'h1, 4'hF, 0, 0, '0);
	endtask

	task automatic readExpect(input axiAddrT addr, input accT exp, input int rDly);
		addEntry(1'b1, addr, '0, '0, 0, rDly, axiDataT'(exp));
	endtask

	task automatic buildTable();
		accT r;
		readExpect(regOffResult, 16'h0, 0); // state right after reset
		readExpect(regOffX, 16'h0, 0);
		clearAcc();
		setX(32'd3, 4'hF, 0);
		pushCoef(32'd5, 4'hF, 0);
		readExpect(regOffResult, modelAcc, 0);
		pushCoef(32'd7, 4'hF, 0);
		readExpect(regOffResult, modelAcc, 0);
		readExpect(regOffX, modelX, 0);
		readExpect(regOffCoef, 16'h0, 0); // write-only registers
		readExpect(regOffCtrl, 16'h0, 0);
		// long polynomial, operands near 2^16 so both words wrap
		clearAcc();
		r = lcgNext();
		setX({16'h0, 4'hF, r[11:0]}, 4'hF, 0);
		for (int i = 0; i < 12; i++) begin
			r = lcgNext();
			pushCoef({16'h0, 4'hF, r[11:0]}, 4'hF, 0);
			readExpect(regOffResult, modelAcc, 0);
		end
		setX(32'h1234, 4'hF, 0);
		setX(32'hABCD, 4'b0001, 0); // low byte only
		readExpect(regOffX, modelX, 0);
		clearAcc();
		pushCoef(32'h5678, 4'b0001, 0);
		readExpect(regOffResult, modelAcc, 0);
		pushCoef(32'hFFFF, 4'b0010, 0);
		readExpect(regOffResult, modelAcc, 0);
		// held responses, next write already offered
		setX(32'h0123, 4'hF, 4);
		r = lcgNext();
		pushCoef({16'h0, r}, 4'hF, 4);
		r = lcgNext();
		pushCoef({16'h0, r}, 4'hF, 4);
		readExpect(regOffResult, modelAcc, 3);
		readExpect(regOffX, modelX, 3);
		pushCoef(32'h9999, 4'hF, 0);
		clearAcc(); // mid-evaluation
		pushCoef(32'h4321, 4'hF, 0);
		readExpect(regOffResult, modelAcc, 0);
		addEntry(1'b0, regOffResult, 32'hFFFF, 4'hF, 0, 0, '0); // dropped
		readExpect(regOffResult, modelAcc, 0);
	endtask

	// starts and ends on a falling edge
	task automatic writeTransfer(input entryT e, input entryT nxt, input logic preOffer);
		awAddr = e.addr;
		wData = e.data;
		wStrb = e.strb;
		awValid = 1'b1;
		wValid = 1'b1;
		#1;
		while (!(awReady && wReady)) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		if (preOffer) begin // must wait behind the held response
			awAddr = nxt.addr;
			wData = nxt.data;
			wStrb = nxt.strb;
		end else begin
			awValid = 1'b0;
			wValid = 1'b0;
		end
		repeat (e.bDly) @(negedge clk);
		bReady = 1'b1;
		#1;
		while (!bValid) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		bReady = 1'b0;
	endtask

	task automatic readTransfer(input entryT e);
		arAddr = e.addr;
		arValid = 1'b1;
		#1;
		while (!arReady) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		arValid = 1'b0;
		repeat (e.rDly) @(negedge clk);
		rReady = 1'b1;
		#1;
		while (!rValid) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		rReady = 1'b0;
	endtask

	initial begin
		logic preOffer;
		arstN = 1'b0;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		nEntries = 0;
		modelX = '0;
		modelAcc = '0;
		lcgState = 32'd97;
		testIdx = 0;
		doneCount = 0;
		expData = '0;
		buildTable();
		cycleLimit = 30 * nEntries + 100;
		repeat (5) @(posedge clk); // five clock edges in reset
		@(negedge clk);
		arstN = 1'b1;
		for (int i = 0; i < nEntries; i++) begin
			testIdx = i;
			expData = stim[i].exp;
			if (stim[i].isRead) begin
				readTransfer(stim[i]);
			end else begin
				preOffer = (i + 1 < nEntries) && !stim[i+1].isRead && (stim[i].bDly != 0);
				writeTransfer(stim[i], stim[(i + 1 < nEntries) ? i + 1 : i], preOffer);
			end
			doneCount++; // checker closes the test on the next edge
		end
		repeat (2) @(negedge clk);
		if (testsDone != nEntries) begin
			$display("only %0d of %0d tests were checked", testsDone, nEntries);
		end
		$display("%0d tests run, %0d failed, %0d errors", testsDone, failedCount, errorCount);
		if (errorCount == 0 && testsDone == nEntries) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// run limit scales with the table length
	initial begin
		cycles = 0;
		@(posedge clk);
		while (cycleLimit == 0 || cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a handshake never completed", cycles);
		$display("Errors found");
		$finish;
	end

endmodule

/* tb/hornerChecker.sv */
module hornerChecker
	import hornerPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic awValid,
	input  logic awReady,
	input  logic wValid,
	input  logic wReady,
	input  axiRespT bResp,
	input  logic bValid,
	input  logic bReady,
	input  logic arValid,
	input  logic arReady,
	input  axiDataT rData,
	input  axiRespT rResp,
	input  logic rValid,
	input  logic rReady,
	input  int testIdx, // test now on the bus
	input  axiDataT expData, // expected rData for that test
	input  int doneCount, // tests the driver has finished
	output int errorCount,
	output int failedCount,
	output int testsDone
);
	timeunit 1ns;
	timeprecision 1ps;

	int awCnt, bCnt, arCnt, rCnt; // transfers in the running test
	int errBase; // errorCount when the running test began
	logic holdB, holdR; // response was waiting for ready at the last edge
	axiRespT lastBResp, lastRResp;
	axiDataT lastRData;

	initial begin
		errorCount = 0;
		failedCount = 0;
		testsDone = 0;
		errBase = 0;
		awCnt = 0;
		bCnt = 0;
		arCnt = 0;
		rCnt = 0;
		holdB = 1'b0;
		holdR = 1'b0;
	end

	// every test is exactly one write with its response or one read with its data
	task automatic closeTest();
		int errs;
		if (awCnt != bCnt) begin
			errorCount++;
			$display("test %0d: %0d writes accepted but %0d write responses seen",
				testsDone, awCnt, bCnt);
		end
		if (arCnt != rCnt) begin
			errorCount++;
			$display("test %0d: %0d reads accepted but %0d read responses seen",
				testsDone, arCnt, rCnt);
		end
		if (awCnt + arCnt != 1) begin
			errorCount++;
			$display("test %0d: %0d transfers accepted instead of one", testsDone, awCnt + arCnt);
		end
		errs = errorCount - errBase;
		if (errs == 0) begin
			$display("test %0d passed", testsDone);
		end else begin
			failedCount++;
			$display("test %0d failed with %0d errors", testsDone, errs);
		end
		errBase = errorCount;
		awCnt = 0;
		bCnt = 0;
		arCnt = 0;
		rCnt = 0;
		testsDone++;
	endtask

	always @(posedge clk) begin
		if (!arstN) begin
			if (awReady || wReady || arReady || bValid || rValid) begin
				errorCount++;
				$display("Error at %0t ns: handshake outputs not low in reset", $time);
			end
			holdB = 1'b0;
			holdR = 1'b0;
		end else begin
			if (doneCount != testsDone) closeTest(); // before this edge's transfers
			if (holdB && (!bValid || bResp !== lastBResp)) begin
				errorCount++;
				$display("Error at %0t ns: test %0d, write response changed before bReady",
					$time, testIdx);
			end
			if (holdR && (!rValid || rData !== lastRData || rResp !== lastRResp)) begin
				errorCount++;
				$display("Error at %0t ns: test %0d, read data changed before rReady",
					$time, testIdx);
			end
			if ((awValid && awReady) != (wValid && wReady)) begin
				errorCount++;
				$display("test %0d: write address and data were accepted apart", testIdx);
			end
			if (awValid && awReady) begin
				awCnt++;
				if (bValid) begin // back-pressure broken
					errorCount++;
					$display("test %0d: write accepted while a response was pending", testIdx);
				end
			end
			if (bValid && bReady) begin
				bCnt++;
				if (bResp !== respOkay) begin
					errorCount++;
					$display("Error at %0t ns: test %0d, bResp %b, expected OKAY",
						$time, testIdx, bResp);
				end
			end
			if (arValid && arReady) arCnt++;
			if (rValid && rReady) begin
				rCnt++;
				if (rResp !== respOkay) begin
					errorCount++;
					$display("Error at %0t ns: test %0d, rResp %b, expected OKAY",
						$time, testIdx, rResp);
				end
				if (rData !== expData) begin
					errorCount++;
					$display("Error at %0t ns: test %0d, rData 0x%08h, expected 0x%08h",
						$time, testIdx, rData, expData);
				end
			end
			holdB = bValid && !bReady;
			holdR = rValid && !rReady;
			lastBResp = bResp;
			lastRResp = rResp;
			lastRData = rData;
		end
	end

endmodule

/* hw/HornerEvalTop.sv */
module HornerEvalTop
	import hornerPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  axiAddrT awAddr,
	input  logic awValid,
	output logic awReady,
	input  axiDataT wData,
	input  axiStrbT wStrb,
	input  logic wValid,
	output logic wReady,
	output axiRespT bResp,
	output logic bValid,
	input  logic bReady,
	input  axiAddrT arAddr,
	input  logic arValid,
	output logic arReady,
	output axiDataT rData,
	output axiRespT rResp,
	output logic rValid,
	input  logic rReady
);

	accT x, coef, result;
	logic step, clear; // single-cycle pulses from the register block

	// bus side, x register and push decode
	HornerAxiRegs regs (
		.clk    (clk),
		.arstN  (arstN),
		.awAddr (awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData  (wData),
		.wStrb  (wStrb),
		.wValid (wValid),
		.wReady (wReady),
		.bResp  (bResp),
		.bValid (bValid),
		.bReady (bReady),
		.arAddr (arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData  (rData),
		.rResp  (rResp),
		.rValid (rValid),
		.rReady (rReady),
		.x      (x),
		.coef   (coef),
		.step   (step),
		.clear  (clear),
		.result (result)
	);

	// carry-save horner datapath
	HornerCsvCore #(
		.speed(cprSpeed)
	) core (
		.clk   (clk),
		.arstN (arstN),
		.x     (x),
		.coef  (coef),
		.step  (step),
		.clear (clear),
		.result(result)
	);

endmodule

/* hw/HornerAxiRegs.sv */
module HornerAxiRegs
	import hornerPkg::*;
(
	input  logic clk,
	input  logic arstN,
	// write address
	input  axiAddrT awAddr,
	input  logic awValid,
	output logic awReady,
	// write data
	input  axiDataT wData,
	input  axiStrbT wStrb,
	input  logic wValid,
	output logic wReady,
	// write response
	output axiRespT bResp,
	output logic bValid,
	input  logic bReady,
	// read address
	input  axiAddrT arAddr,
	input  logic arValid,
	output logic arReady,
	// read data
	output axiDataT rData,
	output axiRespT rResp,
	output logic rValid,
	input  logic rReady,
	// core side
	output accT x,
	output accT coef,
	output logic step,
	output logic clear,
	input  accT result
);

	typedef enum logic {wrIdle, wrResp} wrStateT;
	typedef enum logic [1:0] {rdInit, rdIdle, rdResp} rdStateT;

	wrStateT wrState;
	rdStateT rdState;
	logic wrFire; // aw and w taken together
	logic arFire;
	logic [1:0] wrSel, rdSel; // word index from address bits 3:2
	accT laneMask; // strobe expanded to bits

	always_comb begin
		for (int b = 0; b < accWidth / 8; b++) begin
			laneMask[8*b +: 8] = {8{wStrb[b]}};
		end
	end

	// aw and w only accepted as a pair, and never with a response still out
	assign wrFire = awValid & wValid & (wrState == wrIdle);
	assign awReady = wrFire;
	assign wReady = wrFire;
	assign wrSel = awAddr[3:2];

	// masked lanes read as zero
	assign coef = wData[accWidth-1:0] & laneMask;
	assign step = wrFire && (wrSel == regOffCoef[3:2]);
	assign clear = wrFire && (wrSel == regOffCtrl[3:2]) && wData[0];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrState <= wrIdle;
		end else begin
			case (wrState)
				wrIdle: if (wrFire) wrState <= wrResp;
				wrResp: if (bReady) wrState <= wrIdle; // held until taken
				default: wrState <= wrIdle;
			endcase
		end
	end

	assign bValid = (wrState == wrResp);
	assign bResp = respOkay; // every write is OKAY, result writes just dropped

	// x keeps unstrobed lanes, coef already holds the strobed ones
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			x <= '0;
		end else if (wrFire && (wrSel == regOffX[3:2])) begin
			x <= (x & ~laneMask) | coef;
		end
	end

	// one idle cycle after reset before the first read address
	assign arReady = (rdState == rdIdle);
	assign arFire = arValid & arReady;
	assign rdSel = arAddr[3:2];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdState <= rdInit;
		end else begin
			case (rdState)
				rdInit: rdState <= rdIdle;
				rdIdle: if (arValid) rdState <= rdResp;
				rdResp: if (rReady) rdState <= rdIdle;
				default: rdState <= rdIdle;
			endcase
		end
	end

	assign rValid = (rdState == rdResp);
	assign rResp = respOkay;

	// data sampled at acceptance, stays put while rReady is low
	always_ff @(posedge clk) begin
		if (arFire) begin
			case (rdSel)
				regOffX[3:2]: rData <= axiDataT'(x);
				regOffResult[3:2]: rData <= axiDataT'(result);
				default: rData <= '0; // coef and ctrl are write only
			endcase
		end
	end

endmodule

/* hw/HornerCsvCore.sv */
module HornerCsvCore
	import hornerPkg::*;
#(
	parameter int speed = 1 // compressor structure
) (
	input  logic clk,
	input  logic arstN,
	input  accT x, // evaluation point
	input  accT coef, // coefficient for this step
	input  logic step, // acc <= acc*x + coef
	input  logic clear, // acc <= 0, wins over step
	output accT result // acc in binary
);

	accT accS; // accumulator sum word
	accT accC; // accumulator carry word
	prodT ps, pc; // acc*x in carry-save form
	accT nextS, nextC;

	// acc*x straight from the carry-save words
	MulCsvUns #(
		.speed(speed)
	) mulAcc (
		.XS(accS),
		.XC(accC),
		.Y (x),
		.PS(ps),
		.PC(pc)
	);

	// low halves only, everything is mod 2^accWidth
	AddMopCsv #(
		.width(accWidth),
		.depth(3),
		.speed(speed)
	) addCoef (
		.A({coef, pc[accWidth-1:0], ps[accWidth-1:0]}),
		.S(nextS),
		.C(nextC)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			accS <= '0;
			accC <= '0;
		end else if (clear) begin
			accS <= '0;
			accC <= '0;
		end else if (step) begin // one horner step per push
			accS <= nextS;
			accC <= nextC;
		end
	end

	// the only carry-propagate adder, seen only on reads
	assign result = accS + accC;

endmodule

/* hw/MulCsvUns.sv */
module MulCsvUns
	import hornerPkg::*;
#(
	parameter int speed = 1 // compressor structure of the adder tree
) (
	input  accT XS, // multiplier, sum word
	input  accT XC, // multiplier, carry word
	input  accT Y, // multiplicand
	output prodT PS, // product, sum word
	output prodT PC // product, carry word
);

	logic [accWidth*prodWidth-1:0] pp; // accWidth rows of prodWidth bits

	// rows of 0, y or 2y per multiplier digit
	AddMulPPGenUns ppGen (
		.XS(XS),
		.XC(XC),
		.Y (Y),
		.PP(pp)
	);

	// reduce all rows to two words, no carry-propagate stage
	// PS+PC = (XS+XC)*Y mod 2^prodWidth
	AddMopCsv #(
		.width(prodWidth),
		.depth(accWidth),
		.speed(speed)
	) rowAdd (
		.A(pp),
		.S(PS),
		.C(PC)
	);

endmodule

/* hw/AddMopCsv.sv */
module AddMopCsv
	import hornerPkg::*;
#(
	parameter int width = accWidth, // word width
	parameter int depth = 4, // number of operands
	parameter int speed = 1 // compressor structure
) (
	input  logic [depth*width-1:0] A, // operands, operand k at bits k*width
	output logic [width-1:0] S, // sum word
	output logic [width-1:0] C // carry word, already shifted
);

	localparam int icW = cprCarryW(depth); // carries between neighbouring slices

	logic [depth*width-1:0] aByWeight; // bit i of every operand grouped together
	logic [(width+1)*icW-1:0] ic; // carry chain, one group per slice boundary
	logic [width-1:0] ct; // slice carries before the shift

	always_comb begin
		for (int k = 0; k < depth; k++) begin
			for (int i = 0; i < width; i++) begin
				aByWeight[i*depth+k] = A[k*width+i];
			end
		end
	end

	assign ic[icW-1:0] = '0; // nothing enters below bit 0

	for (genvar i = 0; i < width; i++) begin : gBit
		Cpr #(
			.depth(depth),
			.speed(speed)
		) slice (
			.A (aByWeight[i*depth +: depth]),
			.CI(ic[i*icW +: icW]),
			.S (S[i]),
			.C (ct[i]),
			.CO(ic[(i+1)*icW +: icW]) // top group falls off, modulo 2^width
		);
	end

	// slice carry has the weight of the next bit
	assign C = {ct[width-2:0], 1'b0};

endmodule

/* hw/Cpr.sv */
module Cpr
	import hornerPkg::*;
#(
	parameter int depth = 4, // equal-weight input bits
	parameter int speed = 1 // 0 linear chain, 1 tree
) (
	input  logic [depth-1:0] A, // bits of one weight
	input  logic [cprCarryW(depth)-1:0] CI, // intermediate carries from lower slice
	output logic S, // sum, same weight
	output logic C, // carry, next weight
	output logic [cprCarryW(depth)-1:0] CO // intermediate carries to next slice
);

	localparam int nFa = depth - 2; // full adders in this slice
	localparam int qLen = 3 * depth - 5; // inputs + sums + appended carries

	// queue of signals, inputs first, each full adder appends its sum
	logic [qLen-1:0] q;
	logic [nFa-1:0] cot; // full-adder carry outputs

	assign q[depth-1:0] = A;

	// incoming carry i sits right behind sum i
	for (genvar i = 0; i < depth - 3; i++) begin : gAppend
		assign q[depth+2*i+1] = CI[i];
	end

	for (genvar i = 0; i < nFa; i++) begin : gFa
		logic [2:0] fin; // full-adder inputs

		if (speed == 0 && i > 0) begin : gChain
			// next fresh input, carry i-1, previous sum
			assign fin = {q[depth+2*i-2], q[depth+2*i-1], q[i+2]};
		end else begin : gTree
			// oldest three entries of the queue
			assign fin = q[3*i+2 -: 3];
		end

		// full adder
		assign q[depth+2*i] = ^fin;
		assign cot[i] = (fin[0] & fin[1]) | (fin[2] & (fin[0] ^ fin[1]));
	end

	// last sum is the slice sum, last carry leaves as C
	assign S = q[qLen-1];
	assign C = cot[nFa-1];

	if (depth > 3) begin : gCarryOut
		assign CO = cot[depth-4:0];
	end else begin : gNoCarry
		assign CO = CI; // (3,2) slice, zero chain passes straight on
	end

endmodule

/* hw/AddMulPPGenUns.sv */
module AddMulPPGenUns
	import hornerPkg::*;
(
	input  accT XS, // multiplier, sum word
	input  accT XC, // multiplier, carry word
	input  accT Y, // binary multiplicand
	output logic [accWidth*prodWidth-1:0] PP // one row of prodWidth bits per multiplier bit
);

	accT m1; // digit is 1
	accT m2; // digit is 2
	logic [accWidth+1:0] yExt; // y with a zero on each side, gives 2y by index shift

	// each bit pair xs+xc is a digit in {0,1,2}
	assign m1 = XS ^ XC;
	assign m2 = XS & XC;

	assign yExt = {1'b0, Y, 1'b0};

	// row i is 0, y or 2y shifted left by i
	always_comb begin
		PP = '0;
		for (int i = 0; i < accWidth; i++) begin
			for (int k = 0; k <= accWidth; k++) begin
				// bit k of y (m1) or bit k-1 of y (m2, the 2y term)
				PP[i*prodWidth+i+k] = (m1[i] & yExt[k+1]) | (m2[i] & yExt[k]);
			end
		end
	end

	// highest row reaches bit 2*accWidth-1, so nothing falls off the row
	// overflow of the row sum above prodWidth is dropped by the adder

endmodule

/* hw/hornerPkg.sv */
package hornerPkg;

	// datapath widths
	localparam int accWidth = 16; // accumulator, x and coefficient
	localparam int prodWidth = 2 * accWidth; // full multiplier output

	// axi4-lite widths
	localparam int axiAddrWidth = 4;
	localparam int axiDataWidth = 32;

	typedef logic [accWidth-1:0] accT;
	typedef logic [prodWidth-1:0] prodT;
	typedef logic [axiAddrWidth-1:0] axiAddrT;
	typedef logic [axiDataWidth-1:0] axiDataT;
	typedef logic [axiDataWidth/8-1:0] axiStrbT;
	typedef logic [1:0] axiRespT;

	// register byte offsets, bits 3:2 select the word
	localparam axiAddrT regOffX = 4'h0;
	localparam axiAddrT regOffCoef = 4'h4;
	localparam axiAddrT regOffCtrl = 4'h8;
	localparam axiAddrT regOffResult = 4'hC;

	localparam axiRespT respOkay = 2'b00;

	localparam int cprSpeed = 1; // 0 linear compressors, 1 tree compressors

	// width of the intermediate carry bus between compressor slices
	// a (3,2) slice has none, keep one zero bit so the port exists
	function automatic int cprCarryW(int depth);
		return (depth > 3) ? depth - 3 : 1;
	endfunction

endpackage
